// ==== hw/memCtrlPkg.sv ====
package memCtrlPkg;

    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int BYTE_W = 8;
    localparam int LEN_W  = 3;

    typedef logic [ADDR_W-1:0] addrT;
    typedef logic [WORD_W-1:0] wordT;
    typedef logic [BYTE_W-1:0] byteT;
    typedef logic [LEN_W-1:0]  lenT;

    // instruction fetch is always a full word
    localparam lenT FETCH_LEN = 3'd4;

    // sequencer phases
    typedef enum logic [1:0] {
        IDLE = 2'b00,
        RUN  = 2'b01,
        DONE = 2'b10
    } seqStateT;

endpackage

// ==== hw/memReqIf.sv ====
`timescale 1ns/10ps

interface memReqIf;

    logic             valid;
    logic             write;
    memCtrlPkg::addrT addr;
    memCtrlPkg::lenT  len;
    memCtrlPkg::wordT wdata;
    // one-cycle pulse, rdata only meaningful with it
    logic             done;
    memCtrlPkg::wordT rdata;

    modport arb (
        output valid, write, addr, len, wdata,
        input  done, rdata
    );

    modport seq (
        input  valid, write, addr, len, wdata,
        output done, rdata
    );

endinterface

// ==== hw/memArbiter.sv ====
`timescale 1ns/10ps

module memArbiter (
    input  logic             clk,
    input  logic             rst,

    input  logic             i_fetchEn,
    input  memCtrlPkg::addrT i_fetchAddr,

    input  logic             i_dataEn,
    input  logic             i_dataWrite,
    input  memCtrlPkg::lenT  i_dataLen,
    input  memCtrlPkg::addrT i_dataAddr,
    input  memCtrlPkg::wordT i_dataWdata,

    output logic             o_fetchDone,
    output memCtrlPkg::wordT o_fetchInst,
    output logic             o_dataDone,
    output memCtrlPkg::wordT o_dataRdata,

    memReqIf.arb             req
);

    logic grantFetch;
    logic grantData;
    logic grantIdle;
    logic selFetch;
    logic selData;

    assign grantIdle = !grantFetch && !grantData;

    // data port wins a tie while nothing is granted
    assign selData  = grantData || (grantIdle && i_dataEn);
    assign selFetch = grantFetch || (grantIdle && !i_dataEn && i_fetchEn);

    always_ff @(posedge clk) begin
        if (rst) begin
            grantFetch <= 1'b0;
            grantData  <= 1'b0;
        end else if (req.done) begin
            grantFetch <= 1'b0;
            grantData  <= 1'b0;
        end else if (grantIdle) begin
            grantData  <= i_dataEn;
            grantFetch <= !i_dataEn && i_fetchEn;
        end
    end

    // request fields follow whichever port is selected
    assign req.valid = selData || selFetch;
    assign req.write = selData && i_dataWrite;
    assign req.addr  = selData ? i_dataAddr : i_fetchAddr;
    assign req.len   = selData ? i_dataLen : memCtrlPkg::FETCH_LEN;
    assign req.wdata = selData ? i_dataWdata : '0;

    // completion only goes back to the owner of the grant
    assign o_fetchDone = req.done && grantFetch;
    assign o_dataDone  = req.done && grantData;
    assign o_fetchInst = grantFetch ? req.rdata : '0;
    assign o_dataRdata = grantData ? req.rdata : '0;

endmodule

// ==== hw/byteSequencer.sv ====
`timescale 1ns/10ps

module byteSequencer (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_rdy,
    input  memCtrlPkg::byteT i_memRdata,

    output memCtrlPkg::addrT o_memAddr,
    output logic             o_memWrite,
    output memCtrlPkg::byteT o_memWdata,

    memReqIf.seq             req
);

    memCtrlPkg::seqStateT state;

    // issueCnt is the offset on the bus, capCnt the offset coming back
    memCtrlPkg::lenT  issueCnt;
    memCtrlPkg::lenT  capCnt;
    memCtrlPkg::lenT  lenReg;
    memCtrlPkg::lenT  lastIdx;
    logic             writeReg;
    memCtrlPkg::wordT wdataReg;
    memCtrlPkg::wordT rdWord;
    memCtrlPkg::wordT rdMerged;

    logic             prevRdy;
    memCtrlPkg::byteT heldByte;
    memCtrlPkg::byteT curByte;

    logic             accept;
    logic             byteBack;

    assign accept   = (state == memCtrlPkg::IDLE) && req.valid && i_rdy;
    assign lastIdx  = lenReg - memCtrlPkg::lenT'(1);
    // nothing returns in the first run cycle
    assign byteBack = (state == memCtrlPkg::RUN) && (issueCnt != capCnt);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= memCtrlPkg::IDLE;
            issueCnt <= '0;
            capCnt   <= '0;
            writeReg <= 1'b0;
        end else if (i_rdy) begin
            case (state)
                memCtrlPkg::IDLE: begin
                    if (req.valid) begin
                        state    <= memCtrlPkg::RUN;
                        issueCnt <= '0;
                        capCnt   <= '0;
                        writeReg <= req.write;
                    end
                end
                memCtrlPkg::RUN: begin
                    if (byteBack) begin
                        capCnt <= capCnt + memCtrlPkg::lenT'(1);
                    end
                    // last address shown, its byte arrives in the done cycle
                    if (issueCnt == lastIdx) begin
                        state <= memCtrlPkg::DONE;
                    end else begin
                        issueCnt <= issueCnt + memCtrlPkg::lenT'(1);
                    end
                end
                memCtrlPkg::DONE: begin
                    state <= memCtrlPkg::IDLE;
                end
                default: begin
                    state <= memCtrlPkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_rdy) begin
            if (accept) begin
                o_memAddr <= req.addr;
                lenReg    <= req.len;
                wdataReg  <= req.wdata;
                rdWord    <= '0;
            end else if (state == memCtrlPkg::RUN) begin
                if (byteBack) begin
                    rdWord[capCnt[1:0]*memCtrlPkg::BYTE_W +: memCtrlPkg::BYTE_W] <= curByte;
                end
                if (issueCnt != lastIdx) begin
                    o_memAddr <= o_memAddr + memCtrlPkg::addrT'(1);
                end
            end
        end
    end

    // the ram keeps running through a stall, so keep the byte that
    // was due in the first stalled cycle and replay it afterwards
    always_ff @(posedge clk) begin
        if (rst) begin
            prevRdy <= 1'b1;
        end else begin
            prevRdy <= i_rdy;
        end
    end

    always_ff @(posedge clk) begin
        if (prevRdy) begin
            heldByte <= i_memRdata;
        end
    end

    assign curByte = prevRdy ? i_memRdata : heldByte;

    // final byte merged straight from the bus in the done cycle
    always_comb begin
        rdMerged = rdWord;
        rdMerged[capCnt[1:0]*memCtrlPkg::BYTE_W +: memCtrlPkg::BYTE_W] = curByte;
    end

    assign req.done  = (state == memCtrlPkg::DONE) && i_rdy;
    assign req.rdata = writeReg ? '0 : rdMerged;

    // stores go out lowest byte first
    assign o_memWrite = (state == memCtrlPkg::RUN) && writeReg && i_rdy;
    assign o_memWdata = wdataReg[issueCnt[1:0]*memCtrlPkg::BYTE_W +: memCtrlPkg::BYTE_W];

endmodule

// ==== hw/memCtrl.sv ====
`timescale 1ns/10ps

module memCtrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_rdy,

    // instruction fetch
    input  logic             i_fetchEn,
    input  memCtrlPkg::addrT i_fetchAddr,
    output logic             o_fetchDone,
    output memCtrlPkg::wordT o_fetchInst,

    // data load/store
    input  logic             i_dataEn,
    input  logic             i_dataWrite,
    input  memCtrlPkg::lenT  i_dataLen,
    input  memCtrlPkg::addrT i_dataAddr,
    input  memCtrlPkg::wordT i_dataWdata,
    output logic             o_dataDone,
    output memCtrlPkg::wordT o_dataRdata,

    // byte ram
    input  memCtrlPkg::byteT i_memRdata,
    output memCtrlPkg::addrT o_memAddr,
    output logic             o_memWrite,
    output memCtrlPkg::byteT o_memWdata
);

    memReqIf reqIf ();

    memArbiter arbiter_i (
        .clk         (clk),
        .rst         (rst),
        .i_fetchEn   (i_fetchEn),
        .i_fetchAddr (i_fetchAddr),
        .i_dataEn    (i_dataEn),
        .i_dataWrite (i_dataWrite),
        .i_dataLen   (i_dataLen),
        .i_dataAddr  (i_dataAddr),
        .i_dataWdata (i_dataWdata),
        .o_fetchDone (o_fetchDone),
        .o_fetchInst (o_fetchInst),
        .o_dataDone  (o_dataDone),
        .o_dataRdata (o_dataRdata),
        .req         (reqIf.arb)
    );

    byteSequencer sequencer_i (
        .clk        (clk),
        .rst        (rst),
        .i_rdy      (i_rdy),
        .i_memRdata (i_memRdata),
        .o_memAddr  (o_memAddr),
        .o_memWrite (o_memWrite),
        .o_memWdata (o_memWdata),
        .req        (reqIf.seq)
    );

endmodule

// ==== tb/tbClock.sv ====
`timescale 1ns/10ps

module tbClock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held for two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// ==== tb/ramModel.sv ====
`timescale 1ns/10ps

module ramModel (
    input  logic             clk,
    input  memCtrlPkg::addrT i_addr,
    input  logic             i_write,
    input  memCtrlPkg::byteT i_wdata,
    output memCtrlPkg::byteT o_rdata
);

    // 64 KiB window, upper address bits ignored
    memCtrlPkg::byteT mem [0:65535];

    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = memCtrlPkg::byteT'(i) ^ 8'h5A;
        end
        o_rdata = '0;
    end

    // one cycle read latency
    always @(posedge clk) begin
        if (i_write) begin
            mem[i_addr[15:0]] <= i_wdata;
        end
        o_rdata <= mem[i_addr[15:0]];
    end

endmodule

// ==== tb/memCtrlAssertions.sv ====
`timescale 1ns/10ps

module memCtrlAssertions (
    input logic             clk,
    input logic             rst,
    input logic             i_rdy,
    input memCtrlPkg::addrT i_fetchAddr,
    input logic             o_fetchDone,
    input memCtrlPkg::wordT o_fetchInst,
    input logic             i_dataWrite,
    input memCtrlPkg::lenT  i_dataLen,
    input memCtrlPkg::addrT i_dataAddr,
    input memCtrlPkg::wordT i_dataWdata,
    input logic             o_dataDone,
    input memCtrlPkg::wordT o_dataRdata,
    input memCtrlPkg::addrT o_memAddr,
    input logic             o_memWrite,
    input memCtrlPkg::byteT o_memWdata
);

    int failCnt = 0;
    memCtrlPkg::lenT writeCnt;

    // untouched ram bytes, zero above len
    function automatic memCtrlPkg::wordT patternWord(memCtrlPkg::addrT a, memCtrlPkg::lenT len);
        memCtrlPkg::wordT w;
        memCtrlPkg::addrT b;
        w = '0;
        for (int i = 0; i < int'(len); i++) begin
            b = a + memCtrlPkg::addrT'(i);
            w[i*8 +: 8] = b[7:0] ^ 8'h5A;
        end
        return w;
    endfunction

    function automatic memCtrlPkg::byteT storeByte(memCtrlPkg::wordT d, memCtrlPkg::lenT idx);
        return d[idx[1:0]*8 +: 8];
    endfunction

    // writes seen since the last done
    always_ff @(posedge clk) begin
        if (rst || o_dataDone || o_fetchDone) begin
            writeCnt <= '0;
        end else if (o_memWrite) begin
            writeCnt <= writeCnt + memCtrlPkg::lenT'(1);
        end
    end

    aReset: assert property (@(posedge clk) rst |=> (!o_fetchDone && !o_dataDone && !o_memWrite))
        else begin failCnt++; $error("outputs active right after reset"); end

    aStall: assert property (@(posedge clk) disable iff (rst)
        !i_rdy |-> (!o_memWrite && !o_fetchDone && !o_dataDone))
        else begin failCnt++; $error("activity while i_rdy low"); end

    aStoreAddr: assert property (@(posedge clk) disable iff (rst)
        o_memWrite |-> (i_dataWrite && o_memAddr == i_dataAddr + memCtrlPkg::addrT'(writeCnt)))
        else begin failCnt++; $error("store address out of sequence"); end

    aStoreByte: assert property (@(posedge clk) disable iff (rst)
        o_memWrite |-> (o_memWdata == storeByte(i_dataWdata, writeCnt)))
        else begin failCnt++; $error("store byte not taken lowest first"); end

    aStoreCount: assert property (@(posedge clk) disable iff (rst)
        (o_dataDone && i_dataWrite) |-> (writeCnt == i_dataLen))
        else begin failCnt++; $error("wrong number of store writes"); end

    aFetch: assert property (@(posedge clk) disable iff (rst)
        o_fetchDone |-> (o_fetchInst == patternWord(i_fetchAddr, memCtrlPkg::FETCH_LEN)))
        else begin failCnt++; $error("fetched word does not match ram"); end

    // only loads from the area that is never stored to
    aLoad: assert property (@(posedge clk) disable iff (rst)
        (o_dataDone && !i_dataWrite && !i_dataAddr[15])
        |-> (o_dataRdata == patternWord(i_dataAddr, i_dataLen)))
        else begin failCnt++; $error("loaded data does not match ram"); end

endmodule

// ==== tb/memCtrlTb.sv ====
`timescale 1ns/10ps

module memCtrlTb;

    // requests in the run and the worst case cycles of each
    localparam int N_REQ    = 64;
    localparam int REQ_CYC  = 10;
    localparam int MAX_CYC  = N_REQ * REQ_CYC * 3 / 2 + 10;

    logic clk;
    logic rst;
    logic i_rdy;
    logic i_fetchEn;
    memCtrlPkg::addrT i_fetchAddr;
    logic o_fetchDone;
    memCtrlPkg::wordT o_fetchInst;
    logic i_dataEn;
    logic i_dataWrite;
    memCtrlPkg::lenT i_dataLen;
    memCtrlPkg::addrT i_dataAddr;
    memCtrlPkg::wordT i_dataWdata;
    logic o_dataDone;
    memCtrlPkg::wordT o_dataRdata;
    memCtrlPkg::byteT i_memRdata;
    memCtrlPkg::addrT o_memAddr;
    logic o_memWrite;
    memCtrlPkg::byteT o_memWdata;

    int cmpErr = 0;
    int cycles = 0;
    int stallLeft = 0;
    logic stallEn = 1'b0;
    memCtrlPkg::byteT stored [int];

    tbClock clock_i (.clk(clk), .rst(rst));

    ramModel ram_i (
        .clk(clk), .i_addr(o_memAddr), .i_write(o_memWrite),
        .i_wdata(o_memWdata), .o_rdata(i_memRdata)
    );

    memCtrl memCtrl_i (.*);

    bind memCtrl memCtrlAssertions assertions_i (.*);

    function automatic memCtrlPkg::byteT ramByte(memCtrlPkg::addrT a);
        if (stored.exists(int'(a))) begin
            return stored[int'(a)];
        end
        return a[7:0] ^ 8'h5A;
    endfunction

    function automatic memCtrlPkg::wordT expectWord(memCtrlPkg::addrT a, int len);
        memCtrlPkg::wordT w;
        w = '0;
        for (int i = 0; i < len; i++) begin
            w[i*8 +: 8] = ramByte(a + memCtrlPkg::addrT'(i));
        end
        return w;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            cmpErr++;
            $display("error %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // cyc counts cycles from acceptance to the done cycle
    task automatic waitDone(input logic isFetch, output int cyc);
        logic seen;
        seen = 1'b0;
        cyc = -1;
        while (!seen) begin
            @(negedge clk);
            cyc++;
            seen = isFetch ? o_fetchDone : o_dataDone;
        end
    endtask

    task automatic doFetch(input memCtrlPkg::addrT a);
        int cyc;
        @(posedge clk);
        #1;
        stallLeft = 3;
        i_fetchEn = 1'b1;
        i_fetchAddr = a;
        waitDone(1'b1, cyc);
        checkValue("o_fetchInst", expectWord(a, 4), o_fetchInst);
        if (!stallEn) checkValue("fetch latency", 5, cyc);
        @(posedge clk);
        #1 i_fetchEn = 1'b0;
    endtask

    task automatic doData(input logic wr, input memCtrlPkg::addrT a, input int len,
                          input memCtrlPkg::wordT d);
        int cyc;
        @(posedge clk);
        #1;
        stallLeft = 3;
        i_dataEn = 1'b1;
        i_dataWrite = wr;
        i_dataAddr = a;
        i_dataLen = memCtrlPkg::lenT'(len);
        i_dataWdata = d;
        waitDone(1'b0, cyc);
        if (wr) begin
            for (int i = 0; i < len; i++) begin
                stored[int'(a) + i] = d[i*8 +: 8];
            end
        end else begin
            checkValue("o_dataRdata", expectWord(a, len), o_dataRdata);
        end
        if (!stallEn) checkValue("data latency", len + 1, cyc);
        @(posedge clk);
        #1 i_dataEn = 1'b0;
    endtask

    task automatic storeThenLoad(input int len);
        memCtrlPkg::addrT a;
        a = 32'h8000 + ($urandom % 32'h7ff0);
        doData(1'b1, a, len, $urandom);
        doData(1'b0, a, len, '0);
    endtask

    task automatic priorityCase(input memCtrlPkg::addrT fa, input memCtrlPkg::addrT da);
        int cyc;
        @(posedge clk);
        #1;
        i_fetchEn = 1'b1;
        i_fetchAddr = fa;
        i_dataEn = 1'b1;
        i_dataWrite = 1'b0;
        i_dataAddr = da;
        i_dataLen = 3'd2;
        while (!o_dataDone) begin
            @(negedge clk);
            if (o_fetchDone) begin
                cmpErr++;
                $display("fetch completed before the competing data request");
            end
        end
        checkValue("o_dataRdata", expectWord(da, 2), o_dataRdata);
        @(posedge clk);
        #1 i_dataEn = 1'b0;
        // waiting fetch is taken as soon as the sequencer is idle again
        waitDone(1'b1, cyc);
        checkValue("o_fetchInst", expectWord(fa, 4), o_fetchInst);
        checkValue("fetch latency", 5, cyc);
        @(posedge clk);
        #1 i_fetchEn = 1'b0;
    endtask

    // random back-pressure, at most three low cycles per request
    initial begin
        logic stallNow;
        i_rdy = 1'b1;
        forever begin
            @(posedge clk);
            stallNow = stallEn && stallLeft > 0 && ($urandom % 4) == 0;
            if (stallNow) begin
                stallLeft--;
            end
            #1;
            i_rdy = !stallNow;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYC) begin
            $display("timeout after %0d cycles, a request never completed", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        int lens [3];
        void'($urandom(32'h6be7));
        lens = '{1, 2, 4};
        i_fetchEn = 1'b0;
        i_fetchAddr = '0;
        i_dataEn = 1'b0;
        i_dataWrite = 1'b0;
        i_dataLen = '0;
        i_dataAddr = '0;
        i_dataWdata = '0;
        @(negedge rst);
        repeat (8) doFetch($urandom % 32'h3ffc);
        for (int i = 0; i < 12; i++) doData(1'b0, $urandom % 32'h3ffc, lens[i % 3], '0);
        for (int i = 0; i < 12; i++) storeThenLoad(lens[i % 3]);
        priorityCase(32'h0100, 32'h0200);
        priorityCase(32'h0ffc, 32'h1001);
        stallEn = 1'b1;
        for (int i = 0; i < 4; i++) begin
            doFetch($urandom % 32'h3ffc);
            doData(1'b0, $urandom % 32'h3ffc, lens[i % 3], '0);
            storeThenLoad(lens[(i + 1) % 3]);
        end
        stallEn = 1'b0;
        repeat (3) @(posedge clk);
        $display("errors: compare %0d assertion %0d", cmpErr, memCtrl_i.assertions_i.failCnt);
        if (cmpErr == 0 && memCtrl_i.assertions_i.failCnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== memCtrl.f ====
hw/memCtrlPkg.sv
hw/memReqIf.sv
hw/memArbiter.sv
hw/byteSequencer.sv
hw/memCtrl.sv
tb/tbClock.sv
tb/ramModel.sv
tb/memCtrlAssertions.sv
tb/memCtrlTb.sv

// ==== runSim.sh ====
#!/bin/sh
# compile and run the memCtrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f memCtrl.f --top-module memCtrlTb -o memCtrlSim
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

out=$(./obj_dir/memCtrlSim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx ">>> PASS"; then
    exit 0
fi
exit 1
